// File: f8_core.f
hdl/f8_pkg.sv
hdl/f8_alu.sv
hdl/f8_regfile.sv
hdl/f8_fetch.sv
hdl/f8_execute.sv
hdl/f8_core.sv
sim/f8_core_check.sv
sim/f8_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the f8_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module f8_core_tb -Mdir obj_dir -f f8_core.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vf8_core_tb > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" sim.log; then
	exit 0
fi
exit 1

// File: sim/f8_core_tb.sv
`timescale 1ns/1ps

module f8_core_tb import f8_pkg::*; ();

	localparam logic [15:0] RESET_VECTOR = 16'h4000;
	localparam logic [15:0] DATA_BASE = 16'h8000;
	localparam logic [15:0] RESULT_BASE = 16'h9000;
	localparam int RESULT_DEPTH = 256;

	logic clk = 1'b0;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic iread_valid;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [65536];
	logic [7:0] dmem [65536];
	logic [8:0] expected [RESULT_DEPTH];
	int expected_writes;
	int n_inst;
	int errors;
	int writes;
	logic done;
	logic [15:0] pc_gen;
	logic [15:0] res_ptr;
	logic [15:0] iaddr_q;
	logic [15:0] daddr_q;
	logic [31:0] rng;
	// flags as the program leaves them
	logic mz;
	logic mc;

	always #20 clk = ~clk;

	f8_core #(
		.RESET_VECTOR(RESET_VECTOR)
	) f8_core_i (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.iread_valid(iread_valid),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	f8_core_check #(
		.RESULT_BASE(RESULT_BASE),
		.RESULT_DEPTH(RESULT_DEPTH)
	) check_i (
		.clk(clk),
		.reset(reset),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap),
		.expected(expected),
		.expected_writes(expected_writes),
		.errors(errors),
		.writes(writes),
		.done(done)
	);

	// memories latch their read addresses at the rising edge
	always @(posedge clk)
	begin
		iaddr_q <= iread_addr;
		daddr_q <= dread_addr;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [15:0] rand_bits(int n);
		logic [15:0] r;
		r = 16'h0000;
		for (int i = 0; i < n; i++)
		begin
			r = {r[14:0], rng[0]};
			rng = lfsr_next(rng);
		end
		return r;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'(rand_bits(8));
	endfunction

	// returns {z, c, result}; c only means something for add and sub
	function automatic logic [9:0] f8_ref(alu_op_t op, logic [7:0] a, logic [7:0] b);
		int wide;
		logic [7:0] r;
		logic c;
		c = 1'b0;
		case (op)
			ALU_ADD:
			begin
				wide = int'(a) + int'(b);
				r = wide[7:0];
				c = wide > 255;
			end
			ALU_SUB:
			begin
				r = a - b;
				c = a >= b;
			end
			ALU_AND:
				r = a & b;
			ALU_OR:
				r = a | b;
			ALU_XOR:
				r = a ^ b;
			ALU_INC:
				r = a + 8'd1;
			ALU_DEC:
				r = a - 8'd1;
			default:
				r = b;
		endcase
		return {r == 8'h00, c, r};
	endfunction

	function automatic logic [7:0] imm_opcode(alu_op_t op);
		case (op)
			ALU_ADD:
				return OP_ADD_XL_IMMD;
			ALU_SUB:
				return OP_SUB_XL_IMMD;
			ALU_AND:
				return OP_AND_XL_IMMD;
			ALU_OR:
				return OP_OR_XL_IMMD;
			ALU_XOR:
				return OP_XOR_XL_IMMD;
			ALU_INC:
				return OP_INC_XL;
			ALU_DEC:
				return OP_DEC_XL;
			default:
				return OP_LD_XL_IMMD;
		endcase
	endfunction

	function automatic logic [7:0] dir_opcode(alu_op_t op);
		case (op)
			ALU_ADD:
				return OP_ADD_XL_DIR;
			ALU_SUB:
				return OP_SUB_XL_DIR;
			ALU_AND:
				return OP_AND_XL_DIR;
			ALU_OR:
				return OP_OR_XL_DIR;
			default:
				return OP_XOR_XL_DIR;
		endcase
	endfunction

	task automatic emit_op(input logic [7:0] op);
		imem[pc_gen] = op;
		pc_gen = pc_gen + 16'd1;
		n_inst++;
	endtask

	task automatic emit_byte_op(input logic [7:0] op, input logic [7:0] b);
		imem[pc_gen] = op;
		imem[pc_gen + 16'd1] = b;
		pc_gen = pc_gen + 16'd2;
		n_inst++;
	endtask

	task automatic emit_word_op(input logic [7:0] op, input logic [15:0] w);
		imem[pc_gen] = op;
		imem[pc_gen + 16'd1] = w[7:0];
		imem[pc_gen + 16'd2] = w[15:8];
		pc_gen = pc_gen + 16'd3;
		n_inst++;
	endtask

	task automatic store_byte(input logic [7:0] value);
		emit_word_op(OP_LD_DIR_XL, res_ptr);
		expected[8'(res_ptr - RESULT_BASE)] = {1'b1, value};
		res_ptr = res_ptr + 16'd1;
		expected_writes++;
	endtask

	task automatic store_word(input logic [15:0] value);
		emit_word_op(OP_LDW_DIR_Y, res_ptr);
		expected[8'(res_ptr - RESULT_BASE)] = {1'b1, value[7:0]};
		expected[8'(res_ptr - RESULT_BASE + 16'd1)] = {1'b1, value[15:8]};
		res_ptr = res_ptr + 16'd2;
		expected_writes++;
	endtask

	// one operation on an accumulator that already holds a
	task automatic gen_alu(input alu_op_t op, input logic [7:0] a, input logic [7:0] imm,
			input logic dir, input logic [15:0] daddr, output logic [7:0] r);
		logic [7:0] b;
		logic [9:0] ref_out;
		b = dir ? dmem[daddr] : imm;
		if (dir)
			emit_word_op(dir_opcode(op), daddr);
		else if (op == ALU_INC || op == ALU_DEC)
			emit_op(imm_opcode(op));
		else
			emit_byte_op(imm_opcode(op), imm);
		ref_out = f8_ref(op, a, b);
		r = ref_out[7:0];
		mz = ref_out[9];
		if (op == ALU_ADD || op == ALU_SUB)
			mc = ref_out[8];
	endtask

	task automatic build_program();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] r;
		logic [15:0] w0;
		logic [15:0] w;
		logic [15:0] daddr;
		logic [15:0] target;
		logic [7:0] jop;
		logic [7:0] prefix;
		logic taken;
		alu_op_t op;
		pc_gen = RESET_VECTOR;
		res_ptr = RESULT_BASE;
		n_inst = 0;
		expected_writes = 0;
		mz = 1'b0;
		mc = 1'b0;
		// immediate operands
		for (int round = 0; round < 4; round++)
		begin
			for (int k = 0; k < 7; k++)
			begin
				a = rand_byte();
				b = rand_byte();
				emit_byte_op(OP_LD_XL_IMMD, a);
				gen_alu(alu_op_t'(3'(k)), a, b, 1'b0, 16'h0000, r);
				store_byte(r);
			end
		end
		// direct-memory operands from the preloaded region
		for (int round = 0; round < 4; round++)
		begin
			for (int k = 0; k < 5; k++)
			begin
				a = rand_byte();
				daddr = DATA_BASE + {8'h00, rand_byte()};
				emit_byte_op(OP_LD_XL_IMMD, a);
				gen_alu(alu_op_t'(3'(k)), a, 8'h00, 1'b1, daddr, r);
				store_byte(r);
			end
		end
		// conditional relative jumps over a load of 0
		for (int round = 0; round < 4; round++)
		begin
			for (int j = 0; j < 4; j++)
			begin
				a = rand_byte();
				b = rand_byte();
				// equal operands make Z likely
				if (rand_bits(1) != 0)
					b = a;
				op = ALU_ADD;
				if (rand_bits(1) != 0)
					op = ALU_SUB;
				emit_byte_op(OP_LD_XL_IMMD, a);
				gen_alu(op, a, b, 1'b0, 16'h0000, r);
				emit_byte_op(OP_LD_XL_IMMD, 8'h01);
				case (j)
					0:
					begin
						jop = OP_JRZ_D;
						taken = mz;
					end
					1:
					begin
						jop = OP_JRNZ_D;
						taken = !mz;
					end
					2:
					begin
						jop = OP_JRC_D;
						taken = mc;
					end
					default:
					begin
						jop = OP_JRNC_D;
						taken = !mc;
					end
				endcase
				emit_byte_op(jop, 8'd4);
				emit_byte_op(OP_LD_XL_IMMD, 8'h00);
				store_byte({7'd0, taken});
			end
		end
		// 8-bit work through each prefix and a plain store of XL after it
		for (int p = 0; p < 3; p++)
		begin
			prefix = 8'(OP_ALTACC1) + 8'(p);
			for (int round = 0; round < 2; round++)
			begin
				c = rand_byte();
				a = rand_byte();
				b = rand_byte();
				op = alu_op_t'(3'(int'(rand_bits(3)) % 7));
				emit_byte_op(OP_LD_XL_IMMD, c);
				emit_op(prefix);
				emit_byte_op(OP_LD_XL_IMMD, a);
				emit_op(prefix);
				gen_alu(op, a, b, 1'b0, 16'h0000, r);
				emit_op(prefix);
				store_byte(r);
				store_byte(c);
			end
		end
		// word load and store to Z or X and then Y again
		for (int p = 0; p < 4; p++)
		begin
			prefix = (p < 2) ? 8'(OP_ALTACC2) : 8'(OP_ALTACC3);
			w0 = rand_bits(16);
			w = rand_bits(16);
			emit_word_op(OP_LDW_Y_IMMD, w0);
			emit_op(prefix);
			emit_word_op(OP_LDW_Y_IMMD, w);
			emit_op(prefix);
			store_word(w);
			store_word(w0);
		end
		// unconditional jumps over filler that stores a wrong marker
		for (int round = 0; round < 2; round++)
		begin
			c = rand_byte();
			target = pc_gen + 16'd8;
			emit_word_op(OP_JP_IMMD, target);
			emit_byte_op(OP_LD_XL_IMMD, ~c);
			emit_word_op(OP_LD_DIR_XL, res_ptr);
			emit_byte_op(OP_LD_XL_IMMD, c);
			store_byte(c);
			c = rand_byte();
			emit_byte_op(OP_JR_D, 8'd7);
			emit_byte_op(OP_LD_XL_IMMD, ~c);
			emit_word_op(OP_LD_DIR_XL, res_ptr);
			emit_byte_op(OP_LD_XL_IMMD, c);
			store_byte(c);
		end
		emit_op(OP_TRAP);
	endtask

	initial
	begin
		int cycle;
		int limit;
		logic [1:0] stall_bits;
		reset = 1'b1;
		iread_data = 24'h000000;
		iread_valid = 1'b0;
		dread_data = 16'h0000;
		rng = 32'heb07_54bf;
		for (int i = 0; i < 65536; i++)
		begin
			imem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'ha5;
			dmem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
		end
		for (int i = 0; i < 256; i++)
		begin
			dmem[DATA_BASE + 16'(i)] = rand_byte();
			expected[8'(i)] = 9'h000;
		end
		build_program();
		limit = 4 * n_inst + 100;
		cycle = 0;
		while (done !== 1'b1 && cycle < limit)
		begin
			@(negedge clk);
			if (cycle == 3)
				reset = 1'b0;
			iread_data = {imem[iaddr_q + 16'd2], imem[iaddr_q + 16'd1], imem[iaddr_q]};
			dread_data = {dmem[daddr_q + 16'd1], dmem[daddr_q]};
			stall_bits = 2'(rand_bits(2));
			iread_valid = (stall_bits != 2'b11);
			cycle++;
		end
		if (done !== 1'b1)
			$display("timeout: trap not seen within %0d cycles", limit);
		$display("errors: %0d, data writes: %0d of %0d expected", errors, writes,
			expected_writes);
		if (done === 1'b1 && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: sim/f8_core_check.sv
`timescale 1ns/1ps

module f8_core_check #(
	parameter logic [15:0] RESULT_BASE = 16'h9000,
	parameter int RESULT_DEPTH = 256
) (
	input logic clk,
	input logic reset,
	input logic [15:0] dwrite_addr,
	input logic [15:0] dwrite_data,
	input logic [1:0] dwrite_en,
	input logic trap,
	input logic [8:0] expected [RESULT_DEPTH],
	input int expected_writes,
	output int errors,
	output int writes,
	output logic done
);

	localparam int IDX_W = $clog2(RESULT_DEPTH);

	int err_count = 0;
	int write_count = 0;
	int reset_edges = 0;
	logic finished = 1'b0;

	assign errors = err_count;
	assign writes = write_count;
	assign done = finished;

	// bit 8 of an expected entry marks a byte that the program stores
	task automatic check_byte(input logic [15:0] addr, input logic [7:0] data, input string name);
		int idx;
		idx = int'(addr - RESULT_BASE);
		if (idx >= RESULT_DEPTH || expected[IDX_W'(idx)][8] !== 1'b1)
		begin
			$display("data write to address %h where no result is due", addr);
			err_count++;
		end
		else if (data !== expected[IDX_W'(idx)][7:0])
		begin
			$display("ERR %s at %h: got %h, expected %h", name, addr, data,
				expected[IDX_W'(idx)][7:0]);
			err_count++;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			// first edge still shows the power-up state
			if (reset_edges > 0 && (dwrite_en !== 2'b00 || trap !== 1'b0))
			begin
				$display("data write or trap active during reset");
				err_count++;
			end
			reset_edges++;
		end
		else if (!finished)
		begin
			if ($isunknown(dwrite_en) || $isunknown(trap))
			begin
				$display("write enable or trap is unknown after reset");
				err_count++;
			end
			if (dwrite_en[0] === 1'b1)
				check_byte(dwrite_addr, dwrite_data[7:0], "dwrite_data[7:0]");
			if (dwrite_en[1] === 1'b1)
				check_byte(dwrite_addr + 16'd1, dwrite_data[15:8], "dwrite_data[15:8]");
			if (dwrite_en !== 2'b00)
				write_count++;
			if (trap === 1'b1)
			begin
				if (write_count != expected_writes)
				begin
					$display("trap came after %0d data writes instead of %0d",
						write_count, expected_writes);
					err_count++;
				end
				finished = 1'b1;
			end
		end
	end

endmodule

// File: hdl/f8_core.sv
`timescale 1ns/1ps

module f8_core import f8_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic [ADDR_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	input logic iread_valid,
	output logic [ADDR_W-1:0] dread_addr,
	input logic [15:0] dread_data,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [15:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);

	logic [INST_W-1:0] inst;
	logic [7:0] next_flags;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] z;
	logic [1:0] wr_sel;
	logic [1:0] wr_en;
	logic [15:0] wr_data;

	f8_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch_i (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.iread_valid(iread_valid),
		.dread_addr(dread_addr),
		.next_flags(next_flags),
		.inst(inst)
	);

	f8_execute execute_i (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.x(x),
		.y(y),
		.z(z),
		.dread_data(dread_data),
		.next_flags(next_flags),
		.wr_sel(wr_sel),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	f8_regfile regfile_i (
		.clk(clk),
		.wr_sel(wr_sel),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.x(x),
		.y(y),
		.z(z)
	);

endmodule

// File: hdl/f8_execute.sv
`timescale 1ns/1ps

module f8_execute import f8_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [INST_W-1:0] inst,
	input logic [15:0] x,
	input logic [15:0] y,
	input logic [15:0] z,
	input logic [15:0] dread_data,
	output logic [7:0] next_flags,
	output logic [1:0] wr_sel,
	output logic [1:0] wr_en,
	output logic [15:0] wr_data,
	output logic [ADDR_W-1:0] dwrite_addr,
	output logic [15:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);

	logic [7:0] flags;
	opcode_t opcode;
	accsel_t accsel;
	logic [7:0] imm8;
	logic [15:0] imm16;
	logic [7:0] acc;
	logic [1:0] acc_reg;
	logic acc_hi;
	logic [15:0] word;
	logic [1:0] word_reg;
	alu_op_t alu_op;
	logic acc_write;
	logic [7:0] alu_b;
	logic [7:0] alu_result;
	logic alu_c;
	logic alu_z;

	assign opcode = opcode_t'(inst[7:0]);
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];
	assign accsel = accsel_t'(flags[FLAG_ACC_LO +: 2]);

	// accumulator byte and word register after any prefix
	always_comb
	begin
		acc_hi = 1'b0;
		case (accsel)
			ACCSEL_XH_Y:
			begin
				acc = x[15:8];
				acc_reg = 2'd0;
				acc_hi = 1'b1;
				word = y;
				word_reg = 2'd1;
			end
			ACCSEL_YL_Z:
			begin
				acc = y[7:0];
				acc_reg = 2'd1;
				word = z;
				word_reg = 2'd2;
			end
			ACCSEL_ZL_X:
			begin
				acc = z[7:0];
				acc_reg = 2'd2;
				word = x;
				word_reg = 2'd0;
			end
			default:
			begin
				acc = x[7:0];
				acc_reg = 2'd0;
				word = y;
				word_reg = 2'd1;
			end
		endcase
	end

	always_comb
	begin
		acc_write = 1'b1;
		case (opcode)
			OP_ADD_XL_IMMD, OP_ADD_XL_DIR:
				alu_op = ALU_ADD;
			OP_SUB_XL_IMMD, OP_SUB_XL_DIR:
				alu_op = ALU_SUB;
			OP_AND_XL_IMMD, OP_AND_XL_DIR:
				alu_op = ALU_AND;
			OP_OR_XL_IMMD, OP_OR_XL_DIR:
				alu_op = ALU_OR;
			OP_XOR_XL_IMMD, OP_XOR_XL_DIR:
				alu_op = ALU_XOR;
			OP_INC_XL:
				alu_op = ALU_INC;
			OP_DEC_XL:
				alu_op = ALU_DEC;
			OP_LD_XL_IMMD:
				alu_op = ALU_PASS;
			default:
			begin
				alu_op = ALU_PASS;
				acc_write = 1'b0;
			end
		endcase
	end

	assign alu_b = op_is_dir(opcode) ? dread_data[7:0] : imm8;

	f8_alu alu_i (
		.op(alu_op),
		.a(acc),
		.b(alu_b),
		.result(alu_result),
		.c_out(alu_c),
		.z_out(alu_z)
	);

	always_comb
	begin
		next_flags = flags;
		case (opcode)
			OP_ADD_XL_IMMD, OP_ADD_XL_DIR, OP_SUB_XL_IMMD, OP_SUB_XL_DIR:
			begin
				next_flags[FLAG_Z] = alu_z;
				next_flags[FLAG_C] = alu_c;
			end
			OP_AND_XL_IMMD, OP_AND_XL_DIR, OP_OR_XL_IMMD, OP_OR_XL_DIR,
			OP_XOR_XL_IMMD, OP_XOR_XL_DIR, OP_INC_XL, OP_DEC_XL:
				next_flags[FLAG_Z] = alu_z;
			default:
				;
		endcase
		// a prefix lasts for one instruction, bubbles keep it pending
		case (opcode)
			OP_ALTACC1:
				next_flags[FLAG_ACC_LO +: 2] = ACCSEL_XH_Y;
			OP_ALTACC2:
				next_flags[FLAG_ACC_LO +: 2] = ACCSEL_YL_Z;
			OP_ALTACC3:
				next_flags[FLAG_ACC_LO +: 2] = ACCSEL_ZL_X;
			OP_NOP:
				;
			default:
				next_flags[FLAG_ACC_LO +: 2] = ACCSEL_XL_Y;
		endcase
	end

	always_comb
	begin
		wr_sel = acc_reg;
		wr_en = 2'b00;
		wr_data = {alu_result, alu_result};
		dwrite_en = 2'b00;
		dwrite_data = {8'h00, acc};
		if (acc_write)
			wr_en = acc_hi ? 2'b10 : 2'b01;
		case (opcode)
			OP_LDW_Y_IMMD:
			begin
				wr_sel = word_reg;
				wr_en = 2'b11;
				wr_data = imm16;
			end
			OP_LD_DIR_XL:
				dwrite_en = 2'b01;
			OP_LDW_DIR_Y:
			begin
				dwrite_en = 2'b11;
				dwrite_data = word;
			end
			default:
				;
		endcase
	end

	assign dwrite_addr = imm16;
	assign trap = (opcode == OP_TRAP);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= 8'h00;
		else
			flags <= next_flags;
	end

endmodule

// File: hdl/f8_fetch.sv
`timescale 1ns/1ps

module f8_fetch import f8_pkg::*; #(
	parameter logic [ADDR_W-1:0] RESET_VECTOR = 16'h4000
) (
	input logic clk,
	input logic reset,
	output logic [ADDR_W-1:0] iread_addr,
	input logic [INST_W-1:0] iread_data,
	input logic iread_valid,
	output logic [ADDR_W-1:0] dread_addr,
	input logic [7:0] next_flags,
	output logic [INST_W-1:0] inst
);

	// address of the word now on iread_data
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] next_pc;
	logic [INST_W-1:0] next_inst;
	opcode_t next_opcode;
	logic taken;

	// invalid word becomes a bubble
	assign next_inst = iread_valid ? iread_data : {16'h0000, OP_NOP};
	assign next_opcode = opcode_t'(next_inst[7:0]);

	// conditions see the flags left by the instruction executing now
	always_comb
	begin
		case (next_opcode)
			OP_JR_D:
				taken = 1'b1;
			OP_JRZ_D:
				taken = next_flags[FLAG_Z];
			OP_JRNZ_D:
				taken = !next_flags[FLAG_Z];
			OP_JRC_D:
				taken = next_flags[FLAG_C];
			OP_JRNC_D:
				taken = !next_flags[FLAG_C];
			default:
				taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = RESET_VECTOR;
		else if (!iread_valid)
			next_pc = pc;
		else if (next_opcode == OP_JP_IMMD)
			next_pc = next_inst[23:8];
		else if (taken)
			// offset counts from the jump opcode
			next_pc = pc + {{8{next_inst[15]}}, next_inst[15:8]};
		else
			next_pc = pc + ADDR_W'(inst_len(next_opcode));
	end

	assign iread_addr = next_pc;
	assign dread_addr = op_is_dir(next_opcode) ? next_inst[23:8] : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_VECTOR;
			inst <= {16'h0000, OP_NOP};
		end
		else
		begin
			pc <= next_pc;
			inst <= next_inst;
		end
	end

endmodule

// File: hdl/f8_regfile.sv
`timescale 1ns/1ps

module f8_regfile (
	input logic clk,
	input logic [1:0] wr_sel,
	input logic [1:0] wr_en,
	input logic [15:0] wr_data,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic [15:0] z
);

	logic [15:0] regs [3];

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	// high and low bytes written on their own enables
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (wr_sel == 2'(i))
			begin
				if (wr_en[0])
					regs[i][7:0] <= wr_data[7:0];
				if (wr_en[1])
					regs[i][15:8] <= wr_data[15:8];
			end
		end
	end

endmodule

// File: hdl/f8_alu.sv
`timescale 1ns/1ps

module f8_alu import f8_pkg::*; (
	input alu_op_t op,
	input logic [7:0] a,
	input logic [7:0] b,
	output logic [7:0] result,
	output logic c_out,
	output logic z_out
);

	logic [8:0] sum;

	always_comb
	begin
		sum = 9'd0;
		c_out = 1'b0;
		case (op)
			ALU_ADD:
			begin
				sum = {1'b0, a} + {1'b0, b};
				result = sum[7:0];
				c_out = sum[8];
			end
			ALU_SUB:
			begin
				sum = {1'b0, a} - {1'b0, b};
				result = sum[7:0];
				// carry set means no borrow
				c_out = !sum[8];
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			ALU_INC:
				result = a + 8'd1;
			ALU_DEC:
				result = a - 8'd1;
			default:
				result = b;
		endcase
	end

	assign z_out = (result == 8'h00);

endmodule

// File: hdl/f8_pkg.sv
package f8_pkg;

	localparam int INST_W = 24;
	localparam int ADDR_W = 16;

	// bit positions in the flags byte
	localparam int FLAG_C = 1;
	localparam int FLAG_Z = 3;
	localparam int FLAG_ACC_LO = 6;

	typedef enum logic [7:0] {
		OP_NOP         = 8'h00,
		OP_TRAP        = 8'h01,
		OP_ALTACC1     = 8'h02,
		OP_ALTACC2     = 8'h03,
		OP_ALTACC3     = 8'h04,
		OP_ADD_XL_IMMD = 8'h10,
		OP_SUB_XL_IMMD = 8'h11,
		OP_AND_XL_IMMD = 8'h12,
		OP_OR_XL_IMMD  = 8'h13,
		OP_XOR_XL_IMMD = 8'h14,
		OP_INC_XL      = 8'h15,
		OP_DEC_XL      = 8'h16,
		OP_LD_XL_IMMD  = 8'h17,
		OP_ADD_XL_DIR  = 8'h18,
		OP_SUB_XL_DIR  = 8'h19,
		OP_AND_XL_DIR  = 8'h1a,
		OP_OR_XL_DIR   = 8'h1b,
		OP_XOR_XL_DIR  = 8'h1c,
		OP_LD_DIR_XL   = 8'h20,
		OP_LDW_DIR_Y   = 8'h21,
		OP_LDW_Y_IMMD  = 8'h22,
		OP_JP_IMMD     = 8'h30,
		OP_JR_D        = 8'h31,
		OP_JRZ_D       = 8'h32,
		OP_JRNZ_D      = 8'h33,
		OP_JRC_D       = 8'h34,
		OP_JRNC_D      = 8'h35
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_INC  = 3'd5,
		ALU_DEC  = 3'd6,
		ALU_PASS = 3'd7
	} alu_op_t;

	typedef enum logic [1:0] {
		ACCSEL_XL_Y = 2'b00,
		ACCSEL_XH_Y = 2'b01,
		ACCSEL_YL_Z = 2'b10,
		ACCSEL_ZL_X = 2'b11
	} accsel_t;

	// opcodes that read a byte from a direct address
	function automatic logic op_is_dir(opcode_t op);
		case (op)
			OP_ADD_XL_DIR, OP_SUB_XL_DIR, OP_AND_XL_DIR, OP_OR_XL_DIR, OP_XOR_XL_DIR:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic [1:0] inst_len(opcode_t op);
		case (op)
			OP_ADD_XL_DIR, OP_SUB_XL_DIR, OP_AND_XL_DIR, OP_OR_XL_DIR, OP_XOR_XL_DIR,
			OP_LD_DIR_XL, OP_LDW_DIR_Y, OP_LDW_Y_IMMD, OP_JP_IMMD:
				return 2'd3;
			OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD,
			OP_LD_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
				return 2'd2;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage
